//--- hdl/dot_cfg.svh
// Configuration macros for the dot-product engine.
// Bus widths, lane count and the word address offset.

`ifndef DOT_CFG_SVH
`define DOT_CFG_SVH

// --------------------
// Bus widths.
// --------------------
`define DOT_DATA_W 32
`define DOT_ADDR_W 32

// --------------------
// Register map.
// --------------------
// One coefficient register per lane.
`define DOT_NUM_LANES 4
// Byte offset bits below the word address.
`define DOT_ADDR_LSB 2

`endif

//--- hdl/dot_pkg.sv
// Shared types of the dot-product engine.
// Data word, strobe, lane index, lane vector and AXI response.

`include "dot_cfg.svh"

`default_nettype none

package dot_pkg;

    // --------------------
    // Data path types.
    // --------------------
    // One data word or coefficient.
    typedef logic [`DOT_DATA_W-1:0] word_t;

    // One strobe bit per data byte.
    typedef logic [`DOT_DATA_W/8-1:0] strb_t;

    // Index of a register, which is also its lane.
    typedef logic [$clog2(`DOT_NUM_LANES)-1:0] lane_idx_t;

    // One word per lane, lane 0 in the low bits.
    typedef logic [`DOT_NUM_LANES-1:0][`DOT_DATA_W-1:0] word_vec_t;

    // --------------------
    // Bus types.
    // --------------------
    // AXI response codes.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage

`default_nettype wire

//--- hdl/coef_wr_if.sv
// Coefficient write broadcast from the register port to the lanes.

`timescale 1ns/1ns

`default_nettype none

interface coef_wr_if;
    import dot_pkg::*;

    // Single-cycle write strobe.
    logic      wr_en;
    // Target lane of the write.
    lane_idx_t wr_idx;
    // Byte enables of the write.
    strb_t     wr_strb;
    // Write data, merged under the strobes.
    word_t     wr_data;

    // Driver side, in the register port.
    modport port (
        output wr_en,
        output wr_idx,
        output wr_strb,
        output wr_data
    );

    // Receiver side, in every lane.
    modport lane (
        input wr_en,
        input wr_idx,
        input wr_strb,
        input wr_data
    );

endinterface

`default_nettype wire

//--- hdl/axil_reg_port.sv
// AXI4-Lite slave port of the coefficient registers.
// Write handshake and broadcast to the lanes, read multiplexer and R hold.

`include "dot_cfg.svh"

`timescale 1ns/1ns

`default_nettype none

module axil_reg_port (
    input  wire logic                    i_clk,
    input  wire logic                    i_sync_rst,
    // Write address channel.
    input  wire logic [`DOT_ADDR_W-1:0]  i_awaddr,
    input  wire logic                    i_awvalid,
    output var  logic                    o_awready,
    // Write data channel.
    input  wire dot_pkg::word_t          i_wdata,
    input  wire dot_pkg::strb_t          i_wstrb,
    input  wire logic                    i_wvalid,
    output var  logic                    o_wready,
    // Write response channel.
    output var  dot_pkg::resp_t          o_bresp,
    output var  logic                    o_bvalid,
    input  wire logic                    i_bready,
    // Read address channel.
    input  wire logic [`DOT_ADDR_W-1:0]  i_araddr,
    input  wire logic                    i_arvalid,
    output var  logic                    o_arready,
    // Read data channel.
    output var  dot_pkg::word_t          o_rdata,
    output var  dot_pkg::resp_t          o_rresp,
    output var  logic                    o_rvalid,
    input  wire logic                    i_rready,
    // Current coefficients, for readback.
    input  wire dot_pkg::word_vec_t      i_coefs,
    // Write broadcast to the lanes.
    coef_wr_if.port                      o_wr
);
    import dot_pkg::*;

    localparam int IDX_W = $bits(lane_idx_t);

    // --------------------
    // Write path.
    // --------------------
    // High while no write is in progress.
    logic      r_wr_idle;
    // AWREADY and WREADY always pulse together.
    logic      r_wr_ready;
    // Word address of the accepted write.
    lane_idx_t r_wr_idx;
    logic      r_bvalid;

    logic      w_wr_start;
    logic      w_wr_fire;
    logic      w_b_done;

    // Both channels present and the slave idle.
    assign w_wr_start = r_wr_idle && !r_wr_ready && i_awvalid && i_wvalid;
    // AW and W transfer on the same edge.
    assign w_wr_fire  = r_wr_ready && i_awvalid && i_wvalid;
    assign w_b_done   = r_bvalid && i_bready;

    // Idle again only once the response is taken.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_wr_idle <= 1'b1;
        end else if (w_wr_start) begin
            r_wr_idle <= 1'b0;
        end else if (w_b_done) begin
            r_wr_idle <= 1'b1;
        end
    end

    // One-cycle ready pulse after the address is latched.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_wr_ready <= 1'b0;
        end else begin
            r_wr_ready <= w_wr_start;
        end
    end

    // Keep only the word address bits, upper bits alias.
    always_ff @(posedge i_clk) begin
        if (w_wr_start) begin
            r_wr_idx <= i_awaddr[`DOT_ADDR_LSB +: IDX_W];
        end
    end

    // Response follows the ready pulse and waits for BREADY.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_bvalid <= 1'b0;
        end else if (w_wr_fire) begin
            r_bvalid <= 1'b1;
        end else if (w_b_done) begin
            r_bvalid <= 1'b0;
        end
    end

    assign o_awready = r_wr_ready;
    assign o_wready  = r_wr_ready;
    assign o_bvalid  = r_bvalid;
    // Every address decodes.
    assign o_bresp   = RESP_OKAY;

    // Strobe and data go straight to the lanes in the transfer cycle.
    assign o_wr.wr_en   = w_wr_fire;
    assign o_wr.wr_idx  = r_wr_idx;
    assign o_wr.wr_strb = i_wstrb;
    assign o_wr.wr_data = i_wdata;

    // --------------------
    // Read path.
    // --------------------
    logic      r_arready;
    lane_idx_t r_rd_idx;
    logic      r_rvalid;
    word_t     r_rdata;

    logic      w_rd_start;
    logic      w_rd_fire;

    // No new address while read data is still pending.
    assign w_rd_start = i_arvalid && !r_arready && !r_rvalid;
    assign w_rd_fire  = r_arready && i_arvalid;

    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_arready <= 1'b0;
        end else begin
            r_arready <= w_rd_start;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_rd_start) begin
            r_rd_idx <= i_araddr[`DOT_ADDR_LSB +: IDX_W];
        end
    end

    // R data is held until RREADY.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_rvalid <= 1'b0;
        end else if (w_rd_fire) begin
            r_rvalid <= 1'b1;
        end else if (r_rvalid && i_rready) begin
            r_rvalid <= 1'b0;
        end
    end

    // Coefficient multiplexer.
    always_ff @(posedge i_clk) begin
        if (w_rd_fire) begin
            r_rdata <= i_coefs[r_rd_idx];
        end
    end

    assign o_arready = r_arready;
    assign o_rvalid  = r_rvalid;
    assign o_rdata   = r_rdata;
    assign o_rresp   = RESP_OKAY;

endmodule

`default_nettype wire

//--- hdl/coef_lane.sv
// One coefficient lane.
// Byte-strobed coefficient register and registered lane product.

`include "dot_cfg.svh"

`timescale 1ns/1ns

`default_nettype none

module coef_lane #(
    // Register index served by this lane.
    parameter dot_pkg::lane_idx_t LANE_IDX = '0
) (
    input  wire logic           i_clk,
    input  wire logic           i_sync_rst,
    coef_wr_if.lane             i_wr,
    // Vector element for this lane.
    input  wire dot_pkg::word_t i_elem,
    output var  dot_pkg::word_t o_coef,
    output var  dot_pkg::word_t o_prod
);
    import dot_pkg::*;

    word_t r_coef;
    word_t r_prod;

    // --------------------
    // Coefficient register.
    // --------------------
    // Only strobed bytes of the addressed lane change.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_coef <= '0;
        end else if (i_wr.wr_en && (i_wr.wr_idx == LANE_IDX)) begin
            for (int b = 0; b < `DOT_DATA_W/8; b++) begin
                if (i_wr.wr_strb[b]) begin
                    r_coef[b*8 +: 8] <= i_wr.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // --------------------
    // Product stage.
    // --------------------
    // Low word of the product; upper bits fall away.
    always_ff @(posedge i_clk) begin
        r_prod <= r_coef * i_elem;
    end

    assign o_coef = r_coef;
    assign o_prod = r_prod;

endmodule

`default_nettype wire

//--- hdl/dot_sum.sv
// Adder stage of the inner product.
// Sums the lane products and aligns the vector valid.

`include "dot_cfg.svh"

`timescale 1ns/1ns

`default_nettype none

module dot_sum (
    input  wire logic               i_clk,
    input  wire logic               i_sync_rst,
    // Registered lane products.
    input  wire dot_pkg::word_vec_t i_prods,
    input  wire logic               i_vec_valid,
    output var  dot_pkg::word_t     o_in_prod,
    output var  logic               o_in_prod_valid
);
    import dot_pkg::*;

    // Valid after the product stage.
    logic  r_vld_prod;
    word_t w_sum;

    // Modulo 2^32 sum of all lanes.
    always_comb begin
        w_sum = '0;
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            w_sum = w_sum + i_prods[i];
        end
    end

    // --------------------
    // Valid pipeline.
    // --------------------
    // Two stages, matching product and sum.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_vld_prod      <= 1'b0;
            o_in_prod_valid <= 1'b0;
        end else begin
            r_vld_prod      <= i_vec_valid;
            o_in_prod_valid <= r_vld_prod;
        end
    end

    // Sum register runs every cycle.
    always_ff @(posedge i_clk) begin
        o_in_prod <= w_sum;
    end

endmodule

`default_nettype wire

//--- hdl/dot_engine.sv
// Top level of the dot-product engine.
// AXI4-Lite register port, coefficient lanes and product sum.

`include "dot_cfg.svh"

`timescale 1ns/1ns

`default_nettype none

module dot_engine (
    input  wire logic                   i_clk,
    input  wire logic                   i_sync_rst,
    // AXI4-Lite slave.
    input  wire logic [`DOT_ADDR_W-1:0] i_awaddr,
    input  wire logic                   i_awvalid,
    output var  logic                   o_awready,
    input  wire dot_pkg::word_t         i_wdata,
    input  wire dot_pkg::strb_t         i_wstrb,
    input  wire logic                   i_wvalid,
    output var  logic                   o_wready,
    output var  dot_pkg::resp_t         o_bresp,
    output var  logic                   o_bvalid,
    input  wire logic                   i_bready,
    input  wire logic [`DOT_ADDR_W-1:0] i_araddr,
    input  wire logic                   i_arvalid,
    output var  logic                   o_arready,
    output var  dot_pkg::word_t         o_rdata,
    output var  dot_pkg::resp_t         o_rresp,
    output var  logic                   o_rvalid,
    input  wire logic                   i_rready,
    // Vector input, one element per lane.
    input  wire dot_pkg::word_vec_t     i_vec,
    input  wire logic                   i_vec_valid,
    // Inner product, two cycles after the vector.
    output var  dot_pkg::word_t         o_in_prod,
    output var  logic                   o_in_prod_valid
);
    import dot_pkg::*;

    // Coefficients back to the port, products on to the sum.
    word_vec_t w_coefs;
    word_vec_t w_prods;

    coef_wr_if coef_wr ();

    // --------------------
    // Register port.
    // --------------------
    axil_reg_port axil_reg_port_i (
        .i_clk      (i_clk),
        .i_sync_rst (i_sync_rst),
        .i_awaddr   (i_awaddr),
        .i_awvalid  (i_awvalid),
        .o_awready  (o_awready),
        .i_wdata    (i_wdata),
        .i_wstrb    (i_wstrb),
        .i_wvalid   (i_wvalid),
        .o_wready   (o_wready),
        .o_bresp    (o_bresp),
        .o_bvalid   (o_bvalid),
        .i_bready   (i_bready),
        .i_araddr   (i_araddr),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .o_rdata    (o_rdata),
        .o_rresp    (o_rresp),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .i_coefs    (w_coefs),
        .o_wr       (coef_wr.port)
    );

    // --------------------
    // Lanes and sum.
    // --------------------
    for (genvar g = 0; g < `DOT_NUM_LANES; g++) begin : gen_lane
        coef_lane #(
            .LANE_IDX (lane_idx_t'(g))
        ) coef_lane_i (
            .i_clk      (i_clk),
            .i_sync_rst (i_sync_rst),
            .i_wr       (coef_wr.lane),
            .i_elem     (i_vec[g]),
            .o_coef     (w_coefs[g]),
            .o_prod     (w_prods[g])
        );
    end

    dot_sum dot_sum_i (
        .i_clk           (i_clk),
        .i_sync_rst      (i_sync_rst),
        .i_prods         (w_prods),
        .i_vec_valid     (i_vec_valid),
        .o_in_prod       (o_in_prod),
        .o_in_prod_valid (o_in_prod_valid)
    );

endmodule

`default_nettype wire

//--- bench/dot_engine_assert.sv
// Protocol and latency assertions, bound into the dot-product engine top level.

`timescale 1ns/1ns

`default_nettype none

module dot_engine_assert (
    input wire logic           i_clk,
    input wire logic           i_sync_rst,
    input wire logic           i_awready,
    input wire logic           i_wready,
    input wire logic           i_bvalid,
    input wire logic           i_bready,
    input wire logic           i_rvalid,
    input wire dot_pkg::word_t i_rdata,
    input wire logic           i_rready,
    input wire logic           i_vec_valid,
    input wire logic           i_in_prod_valid
);

    // --------------------
    // AXI4-Lite channels.
    // --------------------
    // B stays up until it is taken.
    a_bvalid_hold : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_bvalid && !i_bready |=> i_bvalid)
        else $error("bvalid dropped before bready");

    // R valid and data frozen while stalled.
    a_r_hold : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
        else $error("rvalid or rdata changed before rready");

    a_aw_w_pair : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_awready == i_wready)
        else $error("awready and wready differ");

    // Single-cycle ready pulse.
    a_aw_pulse : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_awready |=> !i_awready)
        else $error("awready high for more than one cycle");

    // --------------------
    // Vector path.
    // --------------------
    a_latency : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        $past(i_vec_valid, 2) == i_in_prod_valid)
        else $error("o_in_prod_valid not two cycles after i_vec_valid");

endmodule

bind dot_engine dot_engine_assert dot_engine_assert_i (
    .i_clk           (i_clk),
    .i_sync_rst      (i_sync_rst),
    .i_awready       (o_awready),
    .i_wready        (o_wready),
    .i_bvalid        (o_bvalid),
    .i_bready        (i_bready),
    .i_rvalid        (o_rvalid),
    .i_rdata         (o_rdata),
    .i_rready        (i_rready),
    .i_vec_valid     (i_vec_valid),
    .i_in_prod_valid (o_in_prod_valid)
);

`default_nettype wire

//--- bench/dot_engine_tb.sv
// Testbench of the dot-product engine.
// AXI4-Lite master tasks, random vectors, reference model and result checker.

`include "dot_cfg.svh"

`timescale 1ns/1ns

`default_nettype none

module dot_engine_tb;
    import dot_pkg::*;

    localparam int CLK_PERIOD = 100;
    // 25 AXI transfers of at most ten cycles each, plus the vectors and drains.
    localparam int NUM_AXI        = 25;
    localparam int NUM_VEC        = 8;
    localparam int TEST_CYCLES    = NUM_AXI * 10 + 2 * NUM_VEC + 40;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                   i_clk;
    logic                   i_sync_rst;
    logic [`DOT_ADDR_W-1:0] i_awaddr;
    logic                   i_awvalid;
    logic                   o_awready;
    word_t                  i_wdata;
    strb_t                  i_wstrb;
    logic                   i_wvalid;
    logic                   o_wready;
    resp_t                  o_bresp;
    logic                   o_bvalid;
    logic                   i_bready;
    logic [`DOT_ADDR_W-1:0] i_araddr;
    logic                   i_arvalid;
    logic                   o_arready;
    word_t                  o_rdata;
    resp_t                  o_rresp;
    logic                   o_rvalid;
    logic                   i_rready;
    word_vec_t              i_vec;
    logic                   i_vec_valid;
    word_t                  o_in_prod;
    logic                   o_in_prod_valid;

    integer    seed = 32'hdc1c52bc;
    int        cycle = 0;
    // Model of the four coefficients that takes each completed write.
    word_vec_t shadow = '0;
    // Expected results and the cycle each one is due in.
    word_t     exp_q[$];
    int        due_q[$];

    dot_engine dot_engine_i (.*);

    // --------------------
    // Clock and timeout.
    // --------------------
    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Error: timeout, the test was still running after %0d cycles", cycle);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic value_error(input string what, input word_t got, input word_t exp);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        abort_run();
    endtask

    // Steps to just after the next rising edge, where inputs change.
    task automatic next_edge();
        @(posedge i_clk);
        #1;
    endtask

    // --------------------
    // Reference model.
    // --------------------
    // Inner product from the low word of every product and of the sum.
    function automatic word_t dot_ref(input word_vec_t vec, input word_vec_t coefs);
        logic [2*`DOT_DATA_W-1:0] prod;
        word_t                    acc;
        acc = '0;
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            prod = {32'b0, coefs[i]} * {32'b0, vec[i]};
            acc  = acc + prod[`DOT_DATA_W-1:0];
        end
        return acc;
    endfunction

    function automatic word_t strb_merge(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < `DOT_DATA_W / 8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Word address bits pick the register; upper bits alias.
    function automatic lane_idx_t addr_idx(input logic [`DOT_ADDR_W-1:0] addr);
        return addr[`DOT_ADDR_LSB +: $bits(lane_idx_t)];
    endfunction

    // --------------------
    // AXI4-Lite master.
    // --------------------
    task automatic drive_write(input logic [`DOT_ADDR_W-1:0] addr, input word_t data,
                               input strb_t strb);
        i_awaddr  = addr;
        i_awvalid = 1'b1;
        i_wdata   = data;
        i_wstrb   = strb;
        i_wvalid  = 1'b1;
    endtask

    task automatic wait_write_accept();
        do begin
            @(negedge i_clk);
        end while (!(o_awready && o_wready));
        next_edge();
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
    endtask

    // Keep BREADY low for hold cycles, then take the response.
    task automatic take_bresp(input int hold);
        do begin
            @(negedge i_clk);
        end while (!o_bvalid);
        for (int i = 0; i < hold; i++) begin
            next_edge();
            @(negedge i_clk);
            assert (o_bvalid && !o_awready) else begin
                $display("Error: bvalid dropped or a write was accepted before bready");
                abort_run();
            end
        end
        next_edge();
        i_bready = 1'b1;
        @(negedge i_clk);
        assert (o_bresp == RESP_OKAY) else value_error("bresp", word_t'(o_bresp), '0);
        next_edge();
        i_bready = 1'b0;
    endtask

    task automatic axi_write(input logic [`DOT_ADDR_W-1:0] addr, input word_t data,
                             input strb_t strb, input int hold);
        drive_write(addr, data, strb);
        wait_write_accept();
        take_bresp(hold);
        shadow[addr_idx(addr)] = strb_merge(shadow[addr_idx(addr)], data, strb);
    endtask

    task automatic drive_read(input logic [`DOT_ADDR_W-1:0] addr);
        i_araddr  = addr;
        i_arvalid = 1'b1;
    endtask

    task automatic wait_read_accept();
        do begin
            @(negedge i_clk);
        end while (!o_arready);
        next_edge();
        i_arvalid = 1'b0;
    endtask

    // Keep RREADY low for hold cycles; data must not move meanwhile.
    task automatic take_rdata(input int hold, input word_t exp);
        word_t first;
        do begin
            @(negedge i_clk);
        end while (!o_rvalid);
        first = o_rdata;
        for (int i = 0; i < hold; i++) begin
            next_edge();
            @(negedge i_clk);
            assert (o_rvalid && (o_rdata == first) && !o_arready) else begin
                $display("Error: read data not held or a read was accepted before rready");
                abort_run();
            end
        end
        next_edge();
        i_rready = 1'b1;
        @(negedge i_clk);
        assert (o_rdata == exp) else value_error("rdata", o_rdata, exp);
        assert (o_rresp == RESP_OKAY) else value_error("rresp", word_t'(o_rresp), '0);
        next_edge();
        i_rready = 1'b0;
    endtask

    task automatic check_read(input logic [`DOT_ADDR_W-1:0] addr, input int hold);
        drive_read(addr);
        wait_read_accept();
        take_rdata(hold, shadow[addr_idx(addr)]);
    endtask

    // --------------------
    // Vector stimulus.
    // --------------------
    // One vector per cycle; its result is due two edges after sampling.
    task automatic send_vectors(input int n);
        word_vec_t vec;
        for (int k = 0; k < n; k++) begin
            for (int i = 0; i < `DOT_NUM_LANES; i++) begin
                vec[i] = $random(seed);
            end
            i_vec       = vec;
            i_vec_valid = 1'b1;
            exp_q.push_back(dot_ref(vec, shadow));
            due_q.push_back(cycle + 2);
            next_edge();
        end
        i_vec_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0) begin
            @(negedge i_clk);
        end
        next_edge();
    endtask

    // Compares each result with the oldest queued value.
    always @(negedge i_clk) begin : result_check
        word_t exp_val;
        int    due;
        if (!i_sync_rst && o_in_prod_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Error: inner product valid at %0t ns with no vector pending", $time);
                abort_run();
            end
            exp_val = exp_q.pop_front();
            due     = due_q.pop_front();
            assert (cycle == due) else value_error("result cycle", word_t'(cycle), word_t'(due));
            assert (o_in_prod == exp_val) else value_error("o_in_prod", o_in_prod, exp_val);
        end
    end

    // --------------------
    // Test sequence.
    // --------------------
    initial begin : main_seq
        word_t wa;
        word_t wb;
        i_sync_rst  = 1'b1;
        i_awaddr    = '0;
        i_awvalid   = 1'b0;
        i_wdata     = '0;
        i_wstrb     = '0;
        i_wvalid    = 1'b0;
        i_bready    = 1'b0;
        i_araddr    = '0;
        i_arvalid   = 1'b0;
        i_rready    = 1'b0;
        i_vec       = '0;
        i_vec_valid = 1'b0;
        repeat (2) @(posedge i_clk);
        #1;
        i_sync_rst = 1'b0;

        $display("Test 1: reset values");
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            check_read(i * 4, 0);
        end
        send_vectors(2);
        wait_drain();

        $display("Test 2: full-strobe writes");
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            axi_write(i * 4, $random(seed), 4'hf, 0);
        end
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            check_read(i * 4, 0);
        end

        $display("Test 3: partial-strobe writes");
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            axi_write(i * 4, $random(seed), strb_t'($random(seed)), 0);
        end
        for (int i = 0; i < `DOT_NUM_LANES; i++) begin
            check_read(i * 4, 0);
        end

        // Second request waits behind a held response.
        $display("Test 4: aliasing and back-pressure");
        wa = $random(seed);
        wb = $random(seed);
        drive_write(32'habcd_0008, wa, 4'hf);
        wait_write_accept();
        drive_write(32'hffff_fff4, wb, 4'hf);
        take_bresp(3);
        shadow[2] = wa;
        wait_write_accept();
        take_bresp(0);
        shadow[1] = wb;
        drive_read(32'h1234_5678);
        wait_read_accept();
        drive_read(32'h8000_0004);
        take_rdata(3, shadow[2]);
        wait_read_accept();
        take_rdata(0, shadow[1]);

        $display("Test 5: vector stream with a coefficient update");
        send_vectors(NUM_VEC);
        axi_write(32'h0000_000c, $random(seed), 4'hf, 0);
        send_vectors(NUM_VEC);
        wait_drain();

        // Idle cycles in which a stray result valid is still caught.
        repeat (4) next_edge();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/dot_pkg.sv
hdl/coef_wr_if.sv
hdl/axil_reg_port.sv
hdl/coef_lane.sv
hdl/dot_sum.sv
hdl/dot_engine.sv
bench/dot_engine_assert.sv
bench/dot_engine_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the dot-product engine testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module dot_engine_tb -f project.f -o dot_engine_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/dot_engine_sim > sim.log 2>&1
cat sim.log

grep -q "^PASS: all tests$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
